//--- include/auctionBus_params.svh
/* Widths, counts and budget constants of the auction bus.
   Included by the package and by every module that sizes ports or counters. */
`ifndef AUCTIONBUS_PARAMS_SVH
`define AUCTIONBUS_PARAMS_SVH

// #################### Bus geometry
`define AB_NUM_MASTERS    4
`define AB_NUM_SLAVES     4
`define AB_ADDR_W         16
`define AB_DATA_W         32
`define AB_SLAVE_SEL_LSB  12     // Top nibble picks the slave

// #################### Auction budget
`define AB_BID_W          4
`define AB_BAL_W          8
`define AB_BALANCE_INIT   100    // Balance after reset
`define AB_BALANCE_MAX    255    // Refill ceiling
`define AB_REFILL_AMOUNT  64
`define AB_REFILL_PERIOD  1024   // Cycles between refills

// #################### Fairness
`define AB_STARVE_LIMIT   16     // Waiting cycles before a master is served first

`endif

//--- source/auctionBusPkg.sv
/* Shared Wishbone request and response structs plus auction types.
   Modules refer to these by scoped names. */
`include "auctionBus_params.svh"

package auctionBusPkg;

    // #################### Wishbone classic payloads

    typedef struct packed {
        logic                  cyc;   // Bus cycle in progress
        logic                  stb;   // Transfer strobe
        logic                  we;    // Write enable
        logic [`AB_ADDR_W-1:0] adr;
        logic [`AB_DATA_W-1:0] dat;   // Write data
    } wbReqT;

    typedef struct packed {
        logic                  ack;
        logic                  err;   // Unmapped address
        logic [`AB_DATA_W-1:0] dat;   // Read data
    } wbRspT;

    // #################### Auction types

    typedef logic [`AB_BID_W-1:0] bidT;

    typedef logic [`AB_BAL_W-1:0] balanceT;

    // One bit per master
    typedef logic [`AB_NUM_MASTERS-1:0] grantT;

    // One bit per slave
    typedef logic [`AB_NUM_SLAVES-1:0] slaveSelT;

endpackage

//--- source/bidAccount.sv
/* Spending balance of one master. The arbiter charges the winning bid
   and pulses refill once per period; refill saturates at the ceiling. */
`include "auctionBus_params.svh"

module bidAccount (
    input  logic                  clk,
    input  logic                  rst,
    input  auctionBusPkg::bidT    charge,
    input  logic                  chargeEn,
    input  logic                  refill,
    output auctionBusPkg::balanceT balance
);

    localparam int SumW = `AB_BAL_W + 1;   // One spare bit for the refill carry

    localparam logic [SumW-1:0] RefillAmt = SumW'(`AB_REFILL_AMOUNT);
    localparam logic [SumW-1:0] BalMax    = SumW'(`AB_BALANCE_MAX);

    logic [SumW-1:0] chargeAmt;
    logic [SumW-1:0] afterCharge;
    logic [SumW-1:0] afterRefill;
    logic [SumW-1:0] nextBal;

    always_comb begin
        chargeAmt   = chargeEn ? SumW'(charge) : '0;
        afterCharge = {1'b0, balance} - chargeAmt;   // Arbiter never charges above balance
        afterRefill = afterCharge + RefillAmt;
        if (!refill) begin
            nextBal = afterCharge;
        end else if (afterRefill > BalMax) begin
            nextBal = BalMax;                          // Clamp at ceiling
        end else begin
            nextBal = afterRefill;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            balance <= auctionBusPkg::balanceT'(`AB_BALANCE_INIT);
        end else begin
            balance <= nextBal[`AB_BAL_W-1:0];
        end
    end

endmodule

//--- source/starvationWatch.sv
/* Per-master wait counters. A master that has waited the starve limit
   is flagged so the arbiter serves it ahead of the auction. */
`include "auctionBus_params.svh"

module starvationWatch (
    input  logic                 clk,
    input  logic                 rst,
    input  auctionBusPkg::grantT waiting,
    output auctionBusPkg::grantT starved
);

    localparam int NumM = `AB_NUM_MASTERS;
    localparam int CntW = $clog2(`AB_STARVE_LIMIT + 1);

    localparam logic [CntW-1:0] Limit = CntW'(`AB_STARVE_LIMIT);

    logic [CntW-1:0] waitCnt [NumM];

    // #################### Wait counters

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NumM; i++) begin
                waitCnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NumM; i++) begin
                if (!waiting[i]) begin
                    waitCnt[i] <= '0;                    // Granted or cyc dropped
                end else if (waitCnt[i] != Limit) begin
                    waitCnt[i] <= waitCnt[i] + 1'b1;     // Holds at limit
                end
            end
        end
    end

    // #################### Flags

    always_comb begin
        for (int i = 0; i < NumM; i++) begin
            starved[i] = (waitCnt[i] == Limit);
        end
    end

endmodule

//--- source/auctionArbiter.sv
/* Auction arbiter. On a free bus it grants the starved requester, else the
   highest affordable bid with rotating ties, and charges the winner. */
`include "auctionBus_params.svh"

module auctionArbiter (
    input  logic                                         clk,
    input  logic                                         rst,
    input  auctionBusPkg::wbReqT [`AB_NUM_MASTERS-1:0]   mstReq,
    input  auctionBusPkg::bidT   [`AB_NUM_MASTERS-1:0]   mstBid,
    output auctionBusPkg::grantT                         owner
);

    localparam int NumM   = `AB_NUM_MASTERS;
    localparam int PtrW   = $clog2(NumM);
    localparam int TimerW = $clog2(`AB_REFILL_PERIOD);

    localparam logic [TimerW-1:0] TimerLast = TimerW'(`AB_REFILL_PERIOD - 1);

    auctionBusPkg::grantT                  reqVec;
    auctionBusPkg::grantT                  waiting;
    auctionBusPkg::grantT                  starved;
    auctionBusPkg::grantT                  winner;
    auctionBusPkg::balanceT [NumM-1:0]     balance;
    auctionBusPkg::bidT     [NumM-1:0]     effBid;
    auctionBusPkg::bidT                    bestBid;
    logic [PtrW-1:0]                       lastPtr;
    logic [PtrW-1:0]                       winIdx;
    logic [PtrW-1:0]                       scanIdx;
    logic [TimerW-1:0]                     refillTimer;
    logic                                  refillPulse;
    logic                                  busFree;
    logic                                  found;

    // #################### Request view

    always_comb begin
        for (int i = 0; i < NumM; i++) begin
            reqVec[i] = mstReq[i].cyc;
            // Unaffordable bid counts as zero and costs nothing
            effBid[i] = (balance[i] >= auctionBusPkg::balanceT'(mstBid[i])) ? mstBid[i] : '0;
        end
    end

    assign waiting = reqVec & ~owner;
    assign busFree = ~|(owner & reqVec);   // No owner or owner dropped cyc

    // #################### Winner selection

    always_comb begin
        winIdx  = lastPtr;
        scanIdx = lastPtr;
        bestBid = '0;
        found   = 1'b0;
        if (|(reqVec & starved)) begin
            for (int i = NumM - 1; i >= 0; i--) begin
                if (reqVec[i] && starved[i]) begin
                    winIdx = PtrW'(i);                   // Lowest index ends up last
                end
            end
            found = 1'b1;
        end else begin
            // Scan starts after last owner so the first tied master wins
            for (int k = 1; k <= NumM; k++) begin
                scanIdx = PtrW'((int'(lastPtr) + k) % NumM);
                if (reqVec[scanIdx] && (!found || effBid[scanIdx] > bestBid)) begin
                    winIdx  = scanIdx;
                    bestBid = effBid[scanIdx];
                    found   = 1'b1;
                end
            end
        end
        winner = found ? (auctionBusPkg::grantT'(1) << winIdx) : '0;
    end

    // #################### Owner and pointer

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            owner   <= '0;
            lastPtr <= '0;
        end else if (busFree) begin
            owner <= winner;                           // Release and regrant at one edge
            if (found) begin
                lastPtr <= winIdx;
            end
        end
    end

    // #################### Refill timer

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            refillTimer <= '0;
        end else begin
            refillTimer <= refillPulse ? '0 : refillTimer + 1'b1;
        end
    end

    assign refillPulse = (refillTimer == TimerLast);

    // #################### Accounts

    for (genvar m = 0; m < NumM; m++) begin : gAcct
        bidAccount acct_i (
            .clk      (clk),
            .rst      (rst),
            .charge   (effBid[m]),
            .chargeEn (busFree & winner[m]),
            .refill   (refillPulse),
            .balance  (balance[m])
        );
    end

    starvationWatch starve_i (
        .clk     (clk),
        .rst     (rst),
        .waiting (waiting),
        .starved (starved)
    );

endmodule

//--- source/slaveRouter.sv
/* Steers the owner's request to the slave picked by the top address nibble
   and returns that slave's response; unmapped addresses get a registered err. */
`include "auctionBus_params.svh"

module slaveRouter (
    input  logic                                        clk,
    input  logic                                        rst,
    input  auctionBusPkg::grantT                        owner,
    input  auctionBusPkg::wbReqT [`AB_NUM_MASTERS-1:0]  mstReq,
    output auctionBusPkg::wbRspT [`AB_NUM_MASTERS-1:0]  mstRsp,
    output auctionBusPkg::wbReqT [`AB_NUM_SLAVES-1:0]   slvReq,
    input  auctionBusPkg::wbRspT [`AB_NUM_SLAVES-1:0]   slvRsp
);

    localparam int NumM = `AB_NUM_MASTERS;
    localparam int NumS = `AB_NUM_SLAVES;
    localparam int SelW = `AB_ADDR_W - `AB_SLAVE_SEL_LSB;

    auctionBusPkg::wbReqT    ownReq;
    auctionBusPkg::wbRspT    selRsp;
    auctionBusPkg::slaveSelT slaveSel;
    logic [SelW-1:0]         nibble;
    logic                    mapped;
    logic                    errQ;

    // #################### Decode

    always_comb begin
        ownReq = '0;
        for (int i = 0; i < NumM; i++) begin
            if (owner[i]) begin
                ownReq = mstReq[i];
            end
        end
        nibble   = ownReq.adr[`AB_SLAVE_SEL_LSB +: SelW];
        mapped   = (nibble < SelW'(NumS));
        slaveSel = (mapped && |owner) ? (auctionBusPkg::slaveSelT'(1) << nibble) : '0;
    end

    // Error pulse one cycle after stb, never two in a row
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            errQ <= 1'b0;
        end else begin
            errQ <= |owner && ownReq.cyc && ownReq.stb && !mapped && !errQ;
        end
    end

    // #################### Steering

    always_comb begin
        selRsp     = '0;
        selRsp.err = errQ;
        for (int j = 0; j < NumS; j++) begin
            slvReq[j] = slaveSel[j] ? ownReq : '0;   // Idle slaves see cyc low
            if (slaveSel[j]) begin
                selRsp = slvRsp[j];
            end
        end
        for (int i = 0; i < NumM; i++) begin
            mstRsp[i] = owner[i] ? selRsp : '0;
        end
    end

endmodule

//--- source/auctionBus.sv
/* Top of the four-master, four-slave auction bus.
   Connects the auction arbiter to the slave router. */
`include "auctionBus_params.svh"

module auctionBus (
    input  logic                                        clk,
    input  logic                                        rst,

    // Master side
    input  auctionBusPkg::wbReqT [`AB_NUM_MASTERS-1:0]  mstReq,
    input  auctionBusPkg::bidT   [`AB_NUM_MASTERS-1:0]  mstBid,
    output auctionBusPkg::wbRspT [`AB_NUM_MASTERS-1:0]  mstRsp,

    // Slave side
    output auctionBusPkg::wbReqT [`AB_NUM_SLAVES-1:0]   slvReq,
    input  auctionBusPkg::wbRspT [`AB_NUM_SLAVES-1:0]   slvRsp
);

    auctionBusPkg::grantT owner;   // One-hot bus owner

    // #################### Arbitration

    auctionArbiter arb_i (
        .clk    (clk),
        .rst    (rst),
        .mstReq (mstReq),
        .mstBid (mstBid),
        .owner  (owner)
    );

    // #################### Routing

    slaveRouter router_i (
        .clk    (clk),
        .rst    (rst),
        .owner  (owner),
        .mstReq (mstReq),
        .mstRsp (mstRsp),
        .slvReq (slvReq),
        .slvRsp (slvRsp)
    );

endmodule

//--- verification/auctionBus_checker.sv
/* Wishbone protocol assertions for the auction bus.
   Bound into every auctionBus instance. */
`include "auctionBus_params.svh"

module auctionBus_checker (
    input logic                                        clk,
    input logic                                        rst,
    input auctionBusPkg::wbReqT [`AB_NUM_MASTERS-1:0]  mstReq,
    input auctionBusPkg::wbRspT [`AB_NUM_MASTERS-1:0]  mstRsp,
    input auctionBusPkg::wbReqT [`AB_NUM_SLAVES-1:0]   slvReq
);

    logic [`AB_NUM_SLAVES-1:0]  slvCyc;
    logic [`AB_NUM_MASTERS-1:0] mstCyc;
    logic [`AB_NUM_MASTERS-1:0] mstAck;
    logic [`AB_NUM_MASTERS-1:0] mstErr;

    always_comb begin
        for (int j = 0; j < `AB_NUM_SLAVES; j++) begin
            slvCyc[j] = slvReq[j].cyc;
        end
        for (int i = 0; i < `AB_NUM_MASTERS; i++) begin
            mstCyc[i] = mstReq[i].cyc;
            mstAck[i] = mstRsp[i].ack;
            mstErr[i] = mstRsp[i].err;
        end
    end

    // #################### Properties

    oneSlave: assert property (@(posedge clk) disable iff (rst) $onehot0(slvCyc))
        else $error("more than one slave has cyc high");

    ackNeedsCyc: assert property (@(posedge clk) disable iff (rst) (mstAck & ~mstCyc) == '0)
        else $error("ack reached a master whose cyc is low");

    quietInReset: assert property (@(posedge clk)
        rst |-> (slvCyc == '0 && mstAck == '0 && mstErr == '0))
        else $error("bus not idle during reset");

endmodule

bind auctionBus auctionBus_checker checker_i (
    .clk    (clk),
    .rst    (rst),
    .mstReq (mstReq),
    .mstRsp (mstRsp),
    .slvReq (slvReq)
);

//--- verification/auctionBus_tb.sv
/* Self-checking testbench for the auction bus. Applies a table of scenarios
   to four masters and four slave models and checks order, routing and data. */
`include "auctionBus_params.svh"

module auctionBus_tb;

    localparam int NumM = `AB_NUM_MASTERS;
    localparam int NumS = `AB_NUM_SLAVES;

    // Multi-master fields of a scenario hold master 3 in the top digits
    typedef struct packed {
        logic                               rstFirst;
        logic [NumM-1:0]                    mask;     // Requesting masters
        logic [NumM-1:0][`AB_BID_W-1:0]     bids;
        logic [NumM-1:0][`AB_ADDR_W-1:0]    addrs;
        logic [NumM-1:0]                    writes;
        logic [7:0]                         delay;    // Slave ack delay in cycles
        logic [3:0]                         rounds;   // Transfers per master
        logic [63:0]                        order;    // First served master in top digit
    } rowT;

    logic                                   clk;
    logic                                   rst;
    auctionBusPkg::wbReqT [NumM-1:0]        mstReq;
    auctionBusPkg::bidT   [NumM-1:0]        mstBid;
    auctionBusPkg::wbRspT [NumM-1:0]        mstRsp;
    auctionBusPkg::wbReqT [NumS-1:0]        slvReq;
    auctionBusPkg::wbRspT [NumS-1:0]        slvRsp;

    rowT                                    rows[$];
    rowT                                    cur;
    int                                     curRow;
    logic [NumM-1:0]                        roundDone;
    int                                     roundsLeft;
    int                                     doneCnt;
    logic [`AB_DATA_W-1:0]                  wData [NumM];
    int                                     slvCnt [NumS];
    logic [NumS-1:0]                        capValid;   // Slave took a request
    logic [`AB_ADDR_W-1:0]                  capAdr [NumS];
    logic [NumS-1:0]                        capWe;
    logic [`AB_DATA_W-1:0]                  capDat [NumS];
    int                                     errors;
    int                                     checks;
    int                                     seed;
    logic                                   timedOut;

    auctionBus dut_i (
        .clk    (clk),
        .rst    (rst),
        .mstReq (mstReq),
        .mstBid (mstBid),
        .mstRsp (mstRsp),
        .slvReq (slvReq),
        .slvRsp (slvRsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // #################### Helpers

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h (row %0d, time %0t)",
                     name, actual, expected, curRow, $time);
        end
    endtask

    function automatic logic [31:0] readPattern(input int slave, input logic [15:0] adr);
        return {8'(slave), 8'h00, adr};   // Slave index on top and address below
    endfunction

    task automatic addRow(input logic rstFirst, input logic [3:0] mask, input logic [15:0] bids,
                          input logic [63:0] addrs, input logic [3:0] writes,
                          input logic [7:0] delay, input logic [3:0] rounds,
                          input logic [63:0] order);
        rowT r;
        r.rstFirst = rstFirst;
        r.mask     = mask;
        r.bids     = bids;
        r.addrs    = addrs;
        r.writes   = writes;
        r.delay    = delay;
        r.rounds   = rounds;
        r.order    = order;
        rows.push_back(r);
    endtask

    task automatic applyReset();
        logic [31:0] quiet;
        rst    = 1'b1;
        mstReq = '0;
        slvRsp = '0;
        for (int j = 0; j < NumS; j++) begin
            slvCnt[j] = 0;
        end
        repeat (8) @(negedge clk);
        quiet = '0;
        for (int i = 0; i < 4; i++) begin
            quiet[i]      = mstRsp[i].ack;
            quiet[4 + i]  = mstRsp[i].err;
            quiet[8 + i]  = slvReq[i].cyc;
            quiet[12 + i] = slvReq[i].stb;
        end
        checkValue("resetQuiet", quiet, '0);
        rst = 1'b0;
    endtask

    // #################### Masters and slaves

    task automatic startRound();
        for (int i = 0; i < NumM; i++) begin
            if (cur.mask[i]) begin
                wData[i]      = cur.writes[i] ? $random(seed) : '0;
                mstReq[i].cyc = 1'b1;
                mstReq[i].stb = 1'b1;
                mstReq[i].we  = cur.writes[i];
                mstReq[i].adr = cur.addrs[i];
                mstReq[i].dat = wData[i];
            end
        end
        roundDone = '0;
        roundsLeft--;
    endtask

    task automatic finishTransfer(input int i, input auctionBusPkg::wbRspT rsp);
        logic [`AB_ADDR_W-1:0] adr;
        logic [3:0]            nib;
        logic [1:0]            sel;
        logic                  expErr;
        adr    = cur.addrs[i];
        nib    = adr[15:12];
        sel    = nib[1:0];
        expErr = (nib >= 4'(NumS));   // No slave behind this nibble
        if (doneCnt < 16) begin
            checkValue("grantOrder", 32'(i), 32'(cur.order[63 - 4 * doneCnt -: 4]));
        end else begin
            errors++;
            $display("Row %0d finished more transfers than its grant order lists", curRow);
        end
        checkValue("mstRsp.err", 32'(rsp.err), 32'(expErr));
        checkValue("mstRsp.ack", 32'(rsp.ack), 32'(!expErr));
        if (!expErr) begin
            checkValue("slaveSeen", 32'(capValid[sel]), 32'd1);
            checkValue("slvReq.adr", 32'(capAdr[sel]), 32'(adr));
            checkValue("slvReq.we", 32'(capWe[sel]), 32'(cur.writes[i]));
            if (cur.writes[i]) begin
                checkValue("slvReq.dat", capDat[sel], wData[i]);
            end else begin
                checkValue("mstRsp.dat", rsp.dat, readPattern(int'(sel), adr));
            end
            capValid[sel] = 1'b0;
        end
        mstReq[i]    = '0;   // Drop cyc until the round ends
        roundDone[i] = 1'b1;
        doneCnt++;
    endtask

    task automatic serveSlaves(input auctionBusPkg::wbReqT [NumS-1:0] req);
        for (int j = 0; j < NumS; j++) begin
            if (slvRsp[j].ack) begin
                slvRsp[j] = '0;   // One-cycle ack
                slvCnt[j] = 0;
            end else if (req[j].cyc && req[j].stb) begin
                checkValue("slaveNibble", 32'(req[j].adr[15:12]), 32'(j));
                slvCnt[j]++;
                if (slvCnt[j] >= int'(cur.delay)) begin
                    slvRsp[j].ack = 1'b1;
                    slvRsp[j].dat = req[j].we ? '0 : readPattern(j, req[j].adr);
                    capValid[j]   = 1'b1;
                    capAdr[j]     = req[j].adr;
                    capWe[j]      = req[j].we;
                    capDat[j]     = req[j].dat;
                end
            end else begin
                slvCnt[j] = 0;
            end
        end
    endtask

    // Samples the bus first and drives it afterwards, just after a falling edge
    task automatic stepCycle();
        auctionBusPkg::wbRspT [NumM-1:0] rspSnap;
        auctionBusPkg::wbReqT [NumS-1:0] reqSnap;
        rspSnap = mstRsp;
        reqSnap = slvReq;
        if (roundDone == cur.mask && roundsLeft > 0) begin
            startRound();
        end else begin
            for (int i = 0; i < NumM; i++) begin
                if (mstReq[i].cyc && (rspSnap[i].ack || rspSnap[i].err)) begin
                    finishTransfer(i, rspSnap[i]);
                end
            end
        end
        serveSlaves(reqSnap);
    endtask

    task automatic runRow(input int r);
        int expCount;
        int limit;
        int cycles;
        cur    = rows[r];
        curRow = r;
        if (cur.rstFirst) begin
            applyReset();
        end
        mstBid     = cur.bids;
        roundDone  = cur.mask;
        roundsLeft = int'(cur.rounds);
        doneCnt    = 0;
        capValid   = '0;
        expCount   = $countones(cur.mask) * int'(cur.rounds);
        limit      = expCount * (int'(cur.delay) + 8) + 20;
        cycles     = 0;
        while (doneCnt < expCount && cycles < limit) begin
            @(negedge clk);
            stepCycle();
            cycles++;
        end
        if (doneCnt < expCount) begin
            errors++;
            timedOut = 1'b1;
            $display("Timeout in row %0d: %0d of %0d transfers finished after %0d cycles",
                     r, doneCnt, expCount, cycles);
        end else begin
            repeat (3) begin
                @(negedge clk);
                stepCycle();
            end
        end
    endtask

    // #################### Stimulus table

    task automatic buildTable();
        // Routing rows write and read every slave with one master each
        addRow(1'b1, 4'b0001, 16'h0000, 64'h0000_0000_0000_0010, 4'b0001, 8'd1, 4'd1,
               64'h0000_0000_0000_0000);
        addRow(1'b0, 4'b0010, 16'h0000, 64'h0000_0000_1024_0000, 4'b0000, 8'd2, 4'd1,
               64'h1000_0000_0000_0000);
        addRow(1'b0, 4'b0100, 16'h0000, 64'h0000_2abc_0000_0000, 4'b0100, 8'd3, 4'd1,
               64'h2000_0000_0000_0000);
        addRow(1'b0, 4'b1000, 16'h0000, 64'h3ffe_0000_0000_0000, 4'b0000, 8'd1, 4'd1,
               64'h3000_0000_0000_0000);
        addRow(1'b0, 4'b1000, 16'h0000, 64'h0abc_0000_0000_0000, 4'b0000, 8'd2, 4'd1,
               64'h3000_0000_0000_0000);
        addRow(1'b0, 4'b0100, 16'h0000, 64'h0000_1555_0000_0000, 4'b0100, 8'd1, 4'd1,
               64'h2000_0000_0000_0000);
        addRow(1'b0, 4'b0010, 16'h0000, 64'h0000_0000_2468_0000, 4'b0000, 8'd2, 4'd1,
               64'h1000_0000_0000_0000);
        addRow(1'b0, 4'b0001, 16'h0000, 64'h0000_0000_0000_3001, 4'b0001, 8'd1, 4'd1,
               64'h0000_0000_0000_0000);
        // Unmapped nibbles
        addRow(1'b0, 4'b0100, 16'h0000, 64'h0000_4000_0000_0000, 4'b0000, 8'd1, 4'd1,
               64'h2000_0000_0000_0000);
        addRow(1'b0, 4'b0001, 16'h0000, 64'h0000_0000_0000_f123, 4'b0001, 8'd1, 4'd1,
               64'h0000_0000_0000_0000);
        // Bids 3, 12, 7 on masters 0, 1, 3
        addRow(1'b1, 4'b1011, 16'h70c3, 64'h3300_0000_1200_0100, 4'b1001, 8'd2, 4'd1,
               64'h1300_0000_0000_0000);
        // Equal bids after reset start the scan past master 0
        addRow(1'b1, 4'b0101, 16'h0707, 64'h0000_1000_0000_2000, 4'b0001, 8'd1, 4'd3,
               64'h2020_2000_0000_0000);
        // Master 3 wins first so the tie then starts at master 0
        addRow(1'b0, 4'b1101, 16'h9707, 64'h3000_1000_0000_2000, 4'b0001, 8'd1, 4'd2,
               64'h3023_0200_0000_0000);
        // Master 0 runs dry after six wins at 15
        addRow(1'b1, 4'b0011, 16'h001f, 64'h0000_0000_1040_0040, 4'b0010, 8'd1, 4'd8,
               64'h0101_0101_0101_1010);
        // Long stall starves masters 1 and 3
        addRow(1'b1, 4'b1011, 16'h902f, 64'h3030_0000_0020_2010, 4'b0000, 8'd40, 4'd1,
               64'h0130_0000_0000_0000);
    endtask

    // #################### Main sequence

    initial begin
        seed     = 93095;
        errors   = 0;
        checks   = 0;
        curRow   = 0;
        timedOut = 1'b0;
        rst      = 1'b1;
        mstReq   = '0;
        mstBid   = '0;
        slvRsp   = '0;
        buildTable();
        @(negedge clk);
        for (int r = 0; r < rows.size(); r++) begin
            if (!timedOut) begin
                runRow(r);
            end
        end
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- auctionBus.f
+incdir+include
source/auctionBusPkg.sv
source/bidAccount.sv
source/starvationWatch.sv
source/auctionArbiter.sv
source/slaveRouter.sv
source/auctionBus.sv
verification/auctionBus_checker.sv
verification/auctionBus_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the auction bus testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module auctionBus_tb -f auctionBus.f -Mdir obj_dir

simOut=$(./obj_dir/VauctionBus_tb 2>&1) || true
echo "$simOut"

if grep -qxF ">>> PASS" <<< "$simOut"; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1
